//--- include/ooo_issue_settings.svh
`ifndef OOO_ISSUE_SETTINGS_SVH
`define OOO_ISSUE_SETTINGS_SVH

// Operand and result width
`define OOO_DATA_W 32

// Physical registers, one tag each
`define OOO_NUM_TAGS 16

// Reservation-station entries per unit class
`define OOO_ALU_ENTRIES 2
`define OOO_MUL_ENTRIES 2

// Multiplier pipeline depth
`define OOO_MUL_STAGES 3

`endif

//--- rtl/ooo_issue_pkg.sv
package ooo_issue_pkg;

  // Instruction opcodes
  typedef enum logic [2:0] {
    OP_LI  = 3'd0, // Load immediate
    OP_ADD = 3'd1,
    OP_SUB = 3'd2,
    OP_AND = 3'd3,
    OP_XOR = 3'd4,
    OP_MUL = 3'd5
  } opcode_e;

  // Functional-unit class of an instruction
  typedef enum logic {
    FU_ALU = 1'b0,
    FU_MUL = 1'b1
  } fu_class_e;

endpackage

//--- rtl/dispatch_decode.sv
`timescale 1ns/1ps
`include "ooo_issue_settings.svh"

module dispatch_decode (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              dispatch_valid,
  input  ooo_issue_pkg::opcode_e            dispatch_opcode,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  dispatch_dest,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  dispatch_src1,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  dispatch_src2,
  input  logic [`OOO_DATA_W-1:0]            dispatch_imm,
  input  logic                              alu_free,
  input  logic                              mul_free,
  input  logic                              cdb_valid,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  cdb_tag,
  output logic                              dispatch_ready,
  output logic                              rs_write,
  output ooo_issue_pkg::fu_class_e          rs_class,
  output ooo_issue_pkg::opcode_e            rs_opcode,
  output logic [$clog2(`OOO_NUM_TAGS)-1:0]  rs_dest,
  output logic [$clog2(`OOO_NUM_TAGS)-1:0]  rs_src1,
  output logic                              rs_src1_ready,
  output logic [$clog2(`OOO_NUM_TAGS)-1:0]  rs_src2,
  output logic                              rs_src2_ready,
  output logic [`OOO_DATA_W-1:0]            rs_imm
);

  logic [`OOO_NUM_TAGS-1:0] tag_ready; // Scoreboard, one bit per physical register
  logic                     is_li;

  assign is_li = (dispatch_opcode == ooo_issue_pkg::OP_LI);

  // Only OP_MUL goes to the multiplier
  assign rs_class = (dispatch_opcode == ooo_issue_pkg::OP_MUL) ?
                    ooo_issue_pkg::FU_MUL : ooo_issue_pkg::FU_ALU;

  assign dispatch_ready = (rs_class == ooo_issue_pkg::FU_MUL) ? mul_free : alu_free;
  assign rs_write       = dispatch_valid && dispatch_ready;

  // Scoreboard bit or a broadcast of the tag this cycle
  assign rs_src1_ready = is_li || tag_ready[dispatch_src1] ||
                         (cdb_valid && cdb_tag == dispatch_src1);
  assign rs_src2_ready = is_li || tag_ready[dispatch_src2] ||
                         (cdb_valid && cdb_tag == dispatch_src2);

  assign rs_opcode = dispatch_opcode;
  assign rs_dest   = dispatch_dest;
  assign rs_src1   = dispatch_src1;
  assign rs_src2   = dispatch_src2;
  assign rs_imm    = dispatch_imm;

  always_ff @(posedge clock) begin
    if (reset) begin
      tag_ready <= '1; // Every register holds a value after reset
    end else begin
      if (cdb_valid) begin
        tag_ready[cdb_tag] <= 1'b1;
      end
      // A new producer of the tag takes precedence
      if (rs_write) begin
        tag_ready[dispatch_dest] <= 1'b0;
      end
    end
  end

endmodule

//--- rtl/reservation_station.sv
`timescale 1ns/1ps
`include "ooo_issue_settings.svh"

module reservation_station (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              rs_write,
  input  ooo_issue_pkg::fu_class_e          rs_class,
  input  ooo_issue_pkg::opcode_e            rs_opcode,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  rs_dest,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  rs_src1,
  input  logic                              rs_src1_ready,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  rs_src2,
  input  logic                              rs_src2_ready,
  input  logic [`OOO_DATA_W-1:0]            rs_imm,
  input  logic                              alu_accept,
  input  logic                              cdb_valid,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  cdb_tag,
  output logic                              alu_free,
  output logic                              mul_free,
  output logic                              alu_issue,
  output ooo_issue_pkg::opcode_e            alu_opcode,
  output logic [$clog2(`OOO_NUM_TAGS)-1:0]  alu_dest,
  output logic [$clog2(`OOO_NUM_TAGS)-1:0]  alu_src1,
  output logic [$clog2(`OOO_NUM_TAGS)-1:0]  alu_src2,
  output logic [`OOO_DATA_W-1:0]            alu_imm,
  output logic                              mul_issue,
  output logic [$clog2(`OOO_NUM_TAGS)-1:0]  mul_dest,
  output logic [$clog2(`OOO_NUM_TAGS)-1:0]  mul_src1,
  output logic [$clog2(`OOO_NUM_TAGS)-1:0]  mul_src2
);

  // ALU entries first, multiplier entries above them
  localparam int N     = `OOO_ALU_ENTRIES + `OOO_MUL_ENTRIES;
  localparam int IDX_W = $clog2(N);
  localparam int TAG_W = $clog2(`OOO_NUM_TAGS);

  logic [N-1:0]           busy;
  logic [N-1:0]           src1_rdy;
  logic [N-1:0]           src2_rdy;
  logic [N-1:0]           wake1;
  logic [N-1:0]           wake2;
  ooo_issue_pkg::opcode_e opcode [N];
  logic [TAG_W-1:0]       dest   [N];
  logic [TAG_W-1:0]       src1   [N];
  logic [TAG_W-1:0]       src2   [N];
  logic [`OOO_DATA_W-1:0] imm    [N];

  logic [IDX_W-1:0] alu_free_idx, mul_free_idx, wr_idx;
  logic [IDX_W-1:0] alu_idx, mul_idx;
  logic             alu_rdy;

  always_comb begin
    alu_free     = 1'b0;
    mul_free     = 1'b0;
    alu_free_idx = '0;
    mul_free_idx = '0;
    alu_rdy      = 1'b0;
    mul_issue    = 1'b0;
    alu_idx      = '0;
    mul_idx      = '0;
    // Walk downward so the lowest index is the last one kept
    for (int i = N - 1; i >= 0; i--) begin
      wake1[i] = src1_rdy[i] || (cdb_valid && cdb_tag == src1[i]);
      wake2[i] = src2_rdy[i] || (cdb_valid && cdb_tag == src2[i]);
      if (i >= `OOO_ALU_ENTRIES) begin
        if (!busy[i]) begin
          mul_free     = 1'b1;
          mul_free_idx = IDX_W'(i);
        end
        if (busy[i] && wake1[i] && wake2[i]) begin
          mul_issue = 1'b1; // Multiplier never stalls
          mul_idx   = IDX_W'(i);
        end
      end else begin
        if (!busy[i]) begin
          alu_free     = 1'b1;
          alu_free_idx = IDX_W'(i);
        end
        if (busy[i] && wake1[i] && wake2[i]) begin
          alu_rdy = 1'b1;
          alu_idx = IDX_W'(i);
        end
      end
    end
  end

  assign wr_idx    = (rs_class == ooo_issue_pkg::FU_MUL) ? mul_free_idx : alu_free_idx;
  assign alu_issue = alu_rdy && alu_accept;

  assign alu_opcode = opcode[alu_idx];
  assign alu_dest   = dest[alu_idx];
  assign alu_src1   = src1[alu_idx];
  assign alu_src2   = src2[alu_idx];
  assign alu_imm    = imm[alu_idx];
  assign mul_dest   = dest[mul_idx];
  assign mul_src1   = src1[mul_idx];
  assign mul_src2   = src2[mul_idx];

  always_ff @(posedge clock) begin
    if (reset) begin
      busy     <= '0;
      src1_rdy <= '0;
      src2_rdy <= '0;
    end else begin
      src1_rdy <= wake1; // CDB wakeup
      src2_rdy <= wake2;
      if (alu_issue) begin
        busy[alu_idx] <= 1'b0;
      end
      if (mul_issue) begin
        busy[mul_idx] <= 1'b0;
      end
      // Written entry was free, so it never collides with an issue
      if (rs_write) begin
        busy[wr_idx]     <= 1'b1;
        src1_rdy[wr_idx] <= rs_src1_ready;
        src2_rdy[wr_idx] <= rs_src2_ready;
      end
    end
  end

  always_ff @(posedge clock) begin
    if (rs_write) begin
      opcode[wr_idx] <= rs_opcode;
      dest[wr_idx]   <= rs_dest;
      src1[wr_idx]   <= rs_src1;
      src2[wr_idx]   <= rs_src2;
      imm[wr_idx]    <= rs_imm;
    end
  end

endmodule

//--- rtl/alu_unit.sv
`timescale 1ns/1ps
`include "ooo_issue_settings.svh"

module alu_unit (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              alu_issue,
  input  ooo_issue_pkg::opcode_e            alu_opcode,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  alu_dest,
  input  logic [`OOO_DATA_W-1:0]            alu_imm,
  input  logic [`OOO_DATA_W-1:0]            alu_operand_a,
  input  logic [`OOO_DATA_W-1:0]            alu_operand_b,
  input  logic                              alu_grant,
  output logic                              alu_accept,
  output logic                              alu_result_valid,
  output logic [$clog2(`OOO_NUM_TAGS)-1:0]  alu_result_tag,
  output logic [`OOO_DATA_W-1:0]            alu_result_value
);

  logic [`OOO_DATA_W-1:0] alu_next;

  always_comb begin
    case (alu_opcode)
      ooo_issue_pkg::OP_LI:  alu_next = alu_imm;
      ooo_issue_pkg::OP_ADD: alu_next = alu_operand_a + alu_operand_b; // Wraps at data width
      ooo_issue_pkg::OP_SUB: alu_next = alu_operand_a - alu_operand_b;
      ooo_issue_pkg::OP_AND: alu_next = alu_operand_a & alu_operand_b;
      ooo_issue_pkg::OP_XOR: alu_next = alu_operand_a ^ alu_operand_b;
      default:               alu_next = '0;
    endcase
  end

  // Free slot, or the held result leaves this cycle
  assign alu_accept = !alu_result_valid || alu_grant;

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_result_valid <= 1'b0;
    end else if (alu_issue) begin
      alu_result_valid <= 1'b1;
    end else if (alu_grant) begin
      alu_result_valid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (alu_issue) begin
      alu_result_tag   <= alu_dest;
      alu_result_value <= alu_next;
    end
  end

endmodule

//--- rtl/mul_unit.sv
`timescale 1ns/1ps
`include "ooo_issue_settings.svh"

module mul_unit (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              mul_issue,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  mul_dest,
  input  logic [`OOO_DATA_W-1:0]            mul_operand_a,
  input  logic [`OOO_DATA_W-1:0]            mul_operand_b,
  output logic                              mul_result_valid,
  output logic [$clog2(`OOO_NUM_TAGS)-1:0]  mul_result_tag,
  output logic [`OOO_DATA_W-1:0]            mul_result_value
);

  localparam int TAG_W = $clog2(`OOO_NUM_TAGS);

  logic                   s1_valid, s2_valid, s3_valid;
  logic [TAG_W-1:0]       s1_tag, s2_tag, s3_tag;
  logic [`OOO_DATA_W-1:0] s1_a, s1_b;
  logic [`OOO_DATA_W-1:0] s2_prod;
  logic [`OOO_DATA_W-1:0] s3_value;

  always_ff @(posedge clock) begin
    if (reset) begin
      s1_valid <= 1'b0;
      s2_valid <= 1'b0;
      s3_valid <= 1'b0;
    end else begin
      s1_valid <= mul_issue;
      s2_valid <= s1_valid;
      s3_valid <= s2_valid;
    end
  end

  always_ff @(posedge clock) begin
    s1_tag   <= mul_dest;       // Stage 1 operand capture
    s1_a     <= mul_operand_a;
    s1_b     <= mul_operand_b;
    s2_tag   <= s1_tag;         // Stage 2 product, low half only
    s2_prod  <= `OOO_DATA_W'(s1_a * s1_b);
    s3_tag   <= s2_tag;         // Stage 3 output
    s3_value <= s2_prod;
  end

  assign mul_result_valid = s3_valid;
  assign mul_result_tag   = s3_tag;
  assign mul_result_value = s3_value;

endmodule

//--- rtl/result_writeback.sv
`timescale 1ns/1ps
`include "ooo_issue_settings.svh"

module result_writeback (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              alu_result_valid,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  alu_result_tag,
  input  logic [`OOO_DATA_W-1:0]            alu_result_value,
  input  logic                              mul_result_valid,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  mul_result_tag,
  input  logic [`OOO_DATA_W-1:0]            mul_result_value,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  read_tag_a,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  read_tag_b,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  read_tag_c,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  read_tag_d,
  output logic                              alu_grant,
  output logic [`OOO_DATA_W-1:0]            read_value_a,
  output logic [`OOO_DATA_W-1:0]            read_value_b,
  output logic [`OOO_DATA_W-1:0]            read_value_c,
  output logic [`OOO_DATA_W-1:0]            read_value_d,
  output logic                              cdb_valid,
  output logic [$clog2(`OOO_NUM_TAGS)-1:0]  cdb_tag,
  output logic [`OOO_DATA_W-1:0]            cdb_value
);

  localparam int TAG_W = $clog2(`OOO_NUM_TAGS);

  logic [`OOO_DATA_W-1:0] regfile [`OOO_NUM_TAGS];

  // Register file read with bypass of the current broadcast
  function automatic logic [`OOO_DATA_W-1:0] read_port(input logic [TAG_W-1:0] tag);
    if (cdb_valid && cdb_tag == tag) begin
      return cdb_value;
    end
    return regfile[tag];
  endfunction

  // Multiplier has fixed timing and always wins
  assign alu_grant = alu_result_valid && !mul_result_valid;
  assign cdb_valid = mul_result_valid || alu_result_valid;
  assign cdb_tag   = mul_result_valid ? mul_result_tag : alu_result_tag;
  assign cdb_value = mul_result_valid ? mul_result_value : alu_result_value;

  always_comb begin
    read_value_a = read_port(read_tag_a);
    read_value_b = read_port(read_tag_b);
    read_value_c = read_port(read_tag_c);
    read_value_d = read_port(read_tag_d);
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      for (int i = 0; i < `OOO_NUM_TAGS; i++) begin
        regfile[i] <= '0;
      end
    end else if (cdb_valid) begin
      regfile[cdb_tag] <= cdb_value; // Written on the broadcast edge
    end
  end

endmodule

//--- rtl/ooo_issue_top.sv
`timescale 1ns/1ps
`include "ooo_issue_settings.svh"

module ooo_issue_top (
  input  logic                              clock,
  input  logic                              reset,
  input  logic                              dispatch_valid,
  input  ooo_issue_pkg::opcode_e            dispatch_opcode,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  dispatch_dest,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  dispatch_src1,
  input  logic [$clog2(`OOO_NUM_TAGS)-1:0]  dispatch_src2,
  input  logic [`OOO_DATA_W-1:0]            dispatch_imm,
  output logic                              dispatch_ready,
  output logic                              cdb_valid,
  output logic [$clog2(`OOO_NUM_TAGS)-1:0]  cdb_tag,
  output logic [`OOO_DATA_W-1:0]            cdb_value
);

  localparam int TAG_W = $clog2(`OOO_NUM_TAGS);

  // Decode to station
  logic                      rs_write, rs_src1_ready, rs_src2_ready;
  ooo_issue_pkg::fu_class_e  rs_class;
  ooo_issue_pkg::opcode_e    rs_opcode;
  logic [TAG_W-1:0]          rs_dest, rs_src1, rs_src2;
  logic [`OOO_DATA_W-1:0]    rs_imm;
  logic                      alu_free, mul_free;

  // Station to units
  logic                      alu_issue, alu_accept, mul_issue;
  ooo_issue_pkg::opcode_e    alu_opcode;
  logic [TAG_W-1:0]          alu_dest, alu_src1, alu_src2;
  logic [TAG_W-1:0]          mul_dest, mul_src1, mul_src2;
  logic [`OOO_DATA_W-1:0]    alu_imm;
  logic [`OOO_DATA_W-1:0]    alu_operand_a, alu_operand_b;
  logic [`OOO_DATA_W-1:0]    mul_operand_a, mul_operand_b;

  // Units to writeback
  logic                      alu_result_valid, mul_result_valid, alu_grant;
  logic [TAG_W-1:0]          alu_result_tag, mul_result_tag;
  logic [`OOO_DATA_W-1:0]    alu_result_value, mul_result_value;

  dispatch_decode u_decode (
    .clock, .reset,
    .dispatch_valid, .dispatch_opcode, .dispatch_dest,
    .dispatch_src1, .dispatch_src2, .dispatch_imm,
    .alu_free, .mul_free, .cdb_valid, .cdb_tag,
    .dispatch_ready, .rs_write, .rs_class, .rs_opcode, .rs_dest,
    .rs_src1, .rs_src1_ready, .rs_src2, .rs_src2_ready, .rs_imm
  );

  reservation_station u_rs (
    .clock, .reset,
    .rs_write, .rs_class, .rs_opcode, .rs_dest,
    .rs_src1, .rs_src1_ready, .rs_src2, .rs_src2_ready, .rs_imm,
    .alu_accept, .cdb_valid, .cdb_tag,
    .alu_free, .mul_free,
    .alu_issue, .alu_opcode, .alu_dest, .alu_src1, .alu_src2, .alu_imm,
    .mul_issue, .mul_dest, .mul_src1, .mul_src2
  );

  alu_unit u_alu (
    .clock, .reset,
    .alu_issue, .alu_opcode, .alu_dest, .alu_imm,
    .alu_operand_a, .alu_operand_b, .alu_grant,
    .alu_accept, .alu_result_valid, .alu_result_tag, .alu_result_value
  );

  mul_unit u_mul (
    .clock, .reset,
    .mul_issue, .mul_dest, .mul_operand_a, .mul_operand_b,
    .mul_result_valid, .mul_result_tag, .mul_result_value
  );

  // Ports a and b feed the ALU, c and d the multiplier
  result_writeback u_wb (
    .clock, .reset,
    .alu_result_valid, .alu_result_tag, .alu_result_value,
    .mul_result_valid, .mul_result_tag, .mul_result_value,
    .read_tag_a   (alu_src1),
    .read_tag_b   (alu_src2),
    .read_tag_c   (mul_src1),
    .read_tag_d   (mul_src2),
    .alu_grant,
    .read_value_a (alu_operand_a),
    .read_value_b (alu_operand_b),
    .read_value_c (mul_operand_a),
    .read_value_d (mul_operand_b),
    .cdb_valid, .cdb_tag, .cdb_value
  );

endmodule

//--- tests/ooo_issue_assert.sv
`timescale 1ns/1ps
`include "ooo_issue_settings.svh"

module ooo_issue_assert (
  input logic                              clock,
  input logic                              reset,
  input logic                              cdb_valid,
  input logic                              alu_issue,
  input logic                              mul_issue,
  input logic                              mul_result_valid,
  input logic                              rs_write,
  input ooo_issue_pkg::fu_class_e          rs_class,
  input logic                              alu_result_valid,
  input logic [$clog2(`OOO_NUM_TAGS)-1:0]  alu_result_tag,
  input logic [`OOO_DATA_W-1:0]            alu_result_value,
  input logic                              alu_grant
);

  logic alu_write;
  logic mul_write;
  int   alu_used; // Occupied station entries per class
  int   mul_used;

  assign alu_write = rs_write && rs_class == ooo_issue_pkg::FU_ALU;
  assign mul_write = rs_write && rs_class == ooo_issue_pkg::FU_MUL;

  always_ff @(posedge clock) begin
    if (reset) begin
      alu_used <= 0;
      mul_used <= 0;
    end else begin
      alu_used <= alu_used + int'(alu_write) - int'(alu_issue);
      mul_used <= mul_used + int'(mul_write) - int'(mul_issue);
    end
  end

  cdb_valid_known: assert property (@(posedge clock) disable iff (reset)
    !$isunknown(cdb_valid))
    else $error("cdb_valid is unknown");

  // A held ALU result is neither dropped nor replaced by a new issue
  alu_issue_blocked: assert property (@(posedge clock) disable iff (reset)
    alu_result_valid && !alu_grant |=>
      alu_result_valid && $stable(alu_result_tag) && $stable(alu_result_value))
    else $error("held ALU result changed before its grant");

  mul_latency: assert property (@(posedge clock) disable iff (reset)
    mul_result_valid == $past(mul_issue, `OOO_MUL_STAGES)) // Fixed pipeline depth
    else $error("mul_result_valid does not follow mul_issue by the pipeline depth");

  dispatch_when_ready: assert property (@(posedge clock) disable iff (reset)
    rs_write |-> (alu_write ? (alu_used < `OOO_ALU_ENTRIES) : (mul_used < `OOO_MUL_ENTRIES)))
    else $error("dispatch transfer into a full reservation station");

endmodule

//--- tests/ooo_issue_tb.sv
`timescale 1ns/1ps
`include "ooo_issue_settings.svh"

module ooo_issue_tb;

  localparam int CLK_PERIOD = 4;
  localparam int TAG_W      = $clog2(`OOO_NUM_TAGS);
  localparam int NUM_ROWS   = 16;
  localparam int NUM_TESTS  = 6;
  localparam int BURST_TEST = 5; // Must see dispatch_ready drop

  logic                   clock;
  logic                   reset;
  logic                   dispatch_valid;
  ooo_issue_pkg::opcode_e dispatch_opcode;
  logic [TAG_W-1:0]       dispatch_dest;
  logic [TAG_W-1:0]       dispatch_src1;
  logic [TAG_W-1:0]       dispatch_src2;
  logic [`OOO_DATA_W-1:0] dispatch_imm;
  logic                   dispatch_ready;
  logic                   cdb_valid;
  logic [TAG_W-1:0]       cdb_tag;
  logic [`OOO_DATA_W-1:0] cdb_value;

  // Stimulus table in program order with destination tag equal to row index
  ooo_issue_pkg::opcode_e row_op   [NUM_ROWS];
  logic [TAG_W-1:0]       row_dest [NUM_ROWS];
  logic [TAG_W-1:0]       row_src1 [NUM_ROWS];
  logic [TAG_W-1:0]       row_src2 [NUM_ROWS];
  logic [`OOO_DATA_W-1:0] row_imm  [NUM_ROWS];
  int                     row_test [NUM_ROWS];
  int                     row_count;

  logic [`OOO_DATA_W-1:0] expected   [`OOO_NUM_TAGS]; // Reference model result per tag
  int                     row_of_tag [`OOO_NUM_TAGS];
  bit                     seen       [`OOO_NUM_TAGS];
  int                     test_pending [NUM_TESTS+1];
  int                     test_errors  [NUM_TESTS+1];
  bit                     test_stalled [NUM_TESTS+1];
  int                     unique_count;
  int                     broadcast_count;
  int                     error_count;
  int                     tests_passed;
  int                     tests_failed;
  logic [31:0]            lcg_state;

  ooo_issue_top uut (
    .clock, .reset,
    .dispatch_valid, .dispatch_opcode, .dispatch_dest,
    .dispatch_src1, .dispatch_src2, .dispatch_imm,
    .dispatch_ready, .cdb_valid, .cdb_tag, .cdb_value
  );

  bind ooo_issue_top ooo_issue_assert u_assert (
    .clock, .reset, .cdb_valid, .alu_issue,
    .mul_issue, .mul_result_valid, .rs_write, .rs_class,
    .alu_result_valid, .alu_result_tag, .alu_result_value, .alu_grant
  );

  initial begin
    clock = 1'b0;
    forever #(CLK_PERIOD / 2) clock = ~clock;
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  function automatic logic [`OOO_DATA_W-1:0] ref_result(input ooo_issue_pkg::opcode_e op,
      input logic [`OOO_DATA_W-1:0] a, input logic [`OOO_DATA_W-1:0] b,
      input logic [`OOO_DATA_W-1:0] imm);
    logic [2*`OOO_DATA_W-1:0] product;
    product = {{`OOO_DATA_W{1'b0}}, a} * {{`OOO_DATA_W{1'b0}}, b};
    case (op)
      ooo_issue_pkg::OP_LI:  return imm;
      ooo_issue_pkg::OP_ADD: return a + b;
      ooo_issue_pkg::OP_SUB: return a - b;
      ooo_issue_pkg::OP_AND: return a & b;
      ooo_issue_pkg::OP_XOR: return a ^ b;
      ooo_issue_pkg::OP_MUL: return product[`OOO_DATA_W-1:0]; // Low half of full product
      default:               return '0;
    endcase
  endfunction

  task automatic add_row(input ooo_issue_pkg::opcode_e op, input int src1, input int src2,
      input int test);
    row_op[row_count]   = op;
    row_dest[row_count] = TAG_W'(row_count);
    row_src1[row_count] = TAG_W'(src1);
    row_src2[row_count] = TAG_W'(src2);
    row_imm[row_count]  = lcg_next();
    row_test[row_count] = test;
    row_count++;
  endtask

  task automatic build_table();
    row_count = 0;
    add_row(ooo_issue_pkg::OP_LI, 0, 0, 2);  // Tag 0
    add_row(ooo_issue_pkg::OP_LI, 0, 0, 2);
    add_row(ooo_issue_pkg::OP_ADD, 0, 1, 3); // Dependent chain from tag 2
    add_row(ooo_issue_pkg::OP_SUB, 2, 0, 3);
    add_row(ooo_issue_pkg::OP_AND, 3, 1, 3);
    add_row(ooo_issue_pkg::OP_XOR, 4, 2, 3);
    add_row(ooo_issue_pkg::OP_MUL, 0, 1, 4); // Independent multiplies
    add_row(ooo_issue_pkg::OP_MUL, 1, 1, 4);
    add_row(ooo_issue_pkg::OP_MUL, 0, 0, 4);
    add_row(ooo_issue_pkg::OP_MUL, 5, 1, 5); // Three ALU ops wait on tag 9
    add_row(ooo_issue_pkg::OP_ADD, 9, 0, 5);
    add_row(ooo_issue_pkg::OP_XOR, 9, 1, 5);
    add_row(ooo_issue_pkg::OP_SUB, 9, 5, 5);
    add_row(ooo_issue_pkg::OP_MUL, 1, 0, 6); // ADD result lands with the product
    add_row(ooo_issue_pkg::OP_LI, 0, 0, 6);
    add_row(ooo_issue_pkg::OP_ADD, 0, 1, 6);
    for (int t = 0; t <= NUM_TESTS; t++) begin
      test_pending[t] = 0;
      test_errors[t]  = 0;
      test_stalled[t] = 1'b0;
    end
    for (int i = 0; i < `OOO_NUM_TAGS; i++) begin
      expected[i] = '0;
      seen[i]     = 1'b0;
    end
    for (int r = 0; r < NUM_ROWS; r++) begin
      expected[row_dest[r]] = ref_result(row_op[r], expected[row_src1[r]],
                                         expected[row_src2[r]], row_imm[r]);
      row_of_tag[row_dest[r]] = r;
      test_pending[row_test[r]]++;
    end
  endtask

  task automatic record_error(input int t);
    test_errors[t]++;
    error_count++;
  endtask

  task automatic finish_test(input int t);
    if (t == BURST_TEST && !test_stalled[t]) begin
      $display("Test %0d: dispatch_ready never dropped during the ALU burst", t);
      record_error(t);
    end
    if (test_errors[t] == 0) begin
      $display("Test %0d done: ok", t);
      tests_passed++;
    end else begin
      $display("Test %0d done: %0d errors", t, test_errors[t]);
      tests_failed++;
    end
  endtask

  // Holds the row on the inputs until the DUT takes it
  task automatic dispatch_row(input int r);
    @(negedge clock);
    dispatch_valid  = 1'b1;
    dispatch_opcode = row_op[r];
    dispatch_dest   = row_dest[r];
    dispatch_src1   = row_src1[r];
    dispatch_src2   = row_src2[r];
    dispatch_imm    = row_imm[r];
    #1;
    while (dispatch_ready !== 1'b1) begin
      test_stalled[row_test[r]] = 1'b1;
      @(negedge clock);
      #1;
    end
    @(posedge clock); // Transfer edge
  endtask

  always @(negedge clock) begin : cdb_monitor
    int r;
    int t;
    if (!reset && cdb_valid === 1'b1) begin
      r = row_of_tag[cdb_tag];
      t = row_test[r];
      broadcast_count++;
      if (seen[cdb_tag]) begin
        $display("Tag 0x%h was broadcast more than once", cdb_tag);
        record_error(t);
      end else begin
        seen[cdb_tag] = 1'b1;
        unique_count++;
        if (cdb_value !== expected[cdb_tag]) begin
          $display("Fail cdb_value tag 0x%h: got 0x%h, expected 0x%h",
                   cdb_tag, cdb_value, expected[cdb_tag]);
          record_error(t);
        end
        if (row_op[r] != ooo_issue_pkg::OP_LI && !(seen[row_src1[r]] && seen[row_src2[r]])) begin
          $display("Tag 0x%h was broadcast before its producers", cdb_tag);
          record_error(t);
        end
        if (row_op[r] == ooo_issue_pkg::OP_MUL) begin
          for (int k = 0; k < r; k++) begin
            if (row_op[k] == ooo_issue_pkg::OP_MUL && !seen[row_dest[k]]) begin
              $display("Multiply tag 0x%h overtook earlier multiply tag 0x%h",
                       cdb_tag, row_dest[k]);
              record_error(t);
            end
          end
        end
        test_pending[t]--;
        if (test_pending[t] == 0) begin
          finish_test(t);
        end
      end
    end
  end

  initial begin
    #(NUM_ROWS * 40 * CLK_PERIOD);
    $display("Timeout with %0d of %0d tags broadcast", unique_count, NUM_ROWS);
    $display("** FAIL **");
    $finish;
  end

  initial begin
    reset           = 1'b1;
    dispatch_valid  = 1'b0;
    dispatch_opcode = ooo_issue_pkg::OP_LI;
    dispatch_dest   = '0;
    dispatch_src1   = '0;
    dispatch_src2   = '0;
    dispatch_imm    = '0;
    lcg_state       = 32'd84383;
    unique_count    = 0;
    broadcast_count = 0;
    error_count     = 0;
    tests_passed    = 0;
    tests_failed    = 0;
    build_table();
    repeat (5) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;
    @(negedge clock);
    if (cdb_valid !== 1'b0) begin
      $display("Fail cdb_valid after reset: got 0x%h, expected 0x0", cdb_valid);
      record_error(1);
    end
    if (dispatch_ready !== 1'b1) begin
      $display("Fail dispatch_ready after reset: got 0x%h, expected 0x1", dispatch_ready);
      record_error(1);
    end
    finish_test(1);
    for (int r = 0; r < NUM_ROWS; r++) begin
      if (r > 0 && row_test[r] != row_test[r-1]) begin
        @(negedge clock);
        dispatch_valid = 1'b0;
        while (unique_count < r) @(posedge clock); // Drain the previous test
      end
      dispatch_row(r);
    end
    @(negedge clock);
    dispatch_valid = 1'b0;
    while (unique_count < NUM_ROWS) @(posedge clock);
    repeat (10) @(posedge clock); // Room for a stray broadcast
    if (broadcast_count != NUM_ROWS) begin
      $display("Saw %0d CDB broadcasts for %0d rows", broadcast_count, NUM_ROWS);
      error_count++;
    end
    $display("Tests passed %0d, failed %0d", tests_passed, tests_failed);
    if (tests_failed == 0 && error_count == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- ooo_issue.f
+incdir+include
rtl/ooo_issue_pkg.sv
rtl/dispatch_decode.sv
rtl/reservation_station.sv
rtl/alu_unit.sv
rtl/mul_unit.sv
rtl/result_writeback.sv
rtl/ooo_issue_top.sv
tests/ooo_issue_assert.sv
tests/ooo_issue_tb.sv

//--- Makefile
# Verilator build and run for ooo_issue

VERILATOR ?= verilator
TOP       ?= ooo_issue_tb
FILELIST  ?= ooo_issue.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -j 0

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build with Verilator, run $(TOP) and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	-./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -qF '** FAIL **' $(LOG); then echo "Simulation reported failure"; exit 1; fi
	@grep -qF '** PASS **' $(LOG) || { echo "No pass result in $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
